// ==== project.f ====
+incdir+.
pad_pkg.sv
llapi_pad_mapper.sv
player_allocator.sv
controller_input_top.sv
tb_controller_input.sv

// ==== tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ========================================================================
// Counters and compare tasks
// ========================================================================

int error_count = 0;
int tests_run = 0;
int tests_passed = 0;
int errors_at_start = 0;

task automatic check_buttons(input string name, input logic [PLAYER_PAD_W-1:0] expected,
		input logic [PLAYER_PAD_W-1:0] actual);
	if (actual !== expected) begin
		$display("[FAIL] %s buttons: expected %h, actual %h", name, expected, actual);
		error_count++;
	end
endtask

task automatic check_stick(input string name, input logic [STICK_W-1:0] expected,
		input logic [STICK_W-1:0] actual);
	if (actual !== expected) begin
		$display("[FAIL] %s stick: expected %h, actual %h", name, expected, actual);
		error_count++;
	end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("[FAIL] %s osd_button: expected %b, actual %b", name, expected, actual);
		error_count++;
	end
endtask

task automatic start_test;
	errors_at_start = error_count;
endtask

// One line per finished test
task automatic finish_test(input string name);
	tests_run++;
	if (error_count == errors_at_start) begin
		tests_passed++;
		$display("[DONE] %s passed", name);
	end else begin
		$display("[DONE] %s had %0d mismatches", name, error_count - errors_at_start);
	end
endtask

`endif

// ==== tb_controller_input.sv ====
`timescale 1ns/100ps

module tb_controller_input import pad_pkg::*; ();

	logic                    clk_1x;
	logic                    RESET;
	logic [LL_BUTTONS_W-1:0] ll_buttons_a;
	logic [LL_ANALOG_W-1:0]  ll_analog_a;
	logic [LL_TYPE_W-1:0]    ll_type_a;
	logic                    ll_en_a;
	logic [LL_BUTTONS_W-1:0] ll_buttons_b;
	logic [LL_ANALOG_W-1:0]  ll_analog_b;
	logic [LL_TYPE_W-1:0]    ll_type_b;
	logic                    ll_en_b;
	logic [PLAYER_PAD_W-1:0] usb0_buttons;
	logic [PLAYER_PAD_W-1:0] usb1_buttons;
	logic [PLAYER_PAD_W-1:0] usb2_buttons;
	logic [STICK_W-1:0]      usb0_stick;
	logic [STICK_W-1:0]      usb1_stick;
	logic [STICK_W-1:0]      usb2_stick;
	logic [PLAYER_PAD_W-1:0] player0_buttons;
	logic [PLAYER_PAD_W-1:0] player1_buttons;
	logic [PLAYER_PAD_W-1:0] player2_buttons;
	logic [PLAYER_PAD_W-1:0] player3_buttons;
	logic [STICK_W-1:0]      player0_stick;
	logic [STICK_W-1:0]      player1_stick;
	logic [STICK_W-1:0]      player2_stick;
	logic [STICK_W-1:0]      player3_stick;
	logic                    osd_button;

	// Expected slot contents
	logic [PLAYER_PAD_W-1:0] exp_btn [NUM_PLAYERS];
	logic [STICK_W-1:0]      exp_stk [NUM_PLAYERS];
	logic                    exp_osd;
	integer                  seed;

	localparam logic [LL_BUTTONS_W-1:0] COMBO_BITS = 32'h0400_0021;

	`include "tb_checks.svh"

	controller_input_top dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #2 clk_1x = ~clk_1x;
	end

	initial begin
		RESET = 1'b0;
		repeat (4) @(posedge clk_1x);
		@(negedge clk_1x);
		RESET = 1'b1;
	end

	// ========================================================================
	// Reference rules
	// ========================================================================

	// Player bits 13..0 take source buttons in this order
	function automatic logic [PLAYER_PAD_W-1:0] map_pad(input logic [LL_BUTTONS_W-1:0] b);
		logic [LL_PAD_W-1:0] m;
		m = {b[2], b[3], b[9], b[8], b[4], b[7], b[6], b[5],
			b[0], b[1], b[27], b[26], b[25], b[24]};
		return PLAYER_PAD_W'(m);
	endfunction

	function automatic logic [STICK_W-1:0] center(input logic [LL_ANALOG_W-1:0] an);
		return {an[15:8] - 8'd128, an[7:0] - 8'd128};
	endfunction

	function automatic logic combo(input logic [LL_BUTTONS_W-1:0] b);
		return b[26] & b[5] & b[0];
	endfunction

	// ========================================================================
	// Drive and compare helpers
	// ========================================================================

	task automatic drive_a(input logic [LL_BUTTONS_W-1:0] b, input logic [LL_ANALOG_W-1:0] an,
			input logic [LL_TYPE_W-1:0] t, input logic en);
		ll_buttons_a = b;
		ll_analog_a  = an;
		ll_type_a    = t;
		ll_en_a      = en;
	endtask

	task automatic drive_b(input logic [LL_BUTTONS_W-1:0] b, input logic [LL_ANALOG_W-1:0] an,
			input logic [LL_TYPE_W-1:0] t, input logic en);
		ll_buttons_b = b;
		ll_analog_b  = an;
		ll_type_b    = t;
		ll_en_b      = en;
	endtask

	// Low bit forced so every USB pad is nonzero
	task automatic randomize_usb;
		usb0_buttons = $random(seed) | 1;
		usb1_buttons = $random(seed) | 1;
		usb2_buttons = $random(seed) | 1;
		usb0_stick   = $random(seed) | 1;
		usb1_stick   = $random(seed) | 1;
		usb2_stick   = $random(seed) | 1;
	endtask

	// Serial path is two registers deep
	task automatic settle_pipeline;
		repeat (2) @(posedge clk_1x);
		@(negedge clk_1x);
	endtask

	task automatic expect_empty;
		for (int i = 0; i < NUM_PLAYERS; i++) begin
			exp_btn[i] = '0;
			exp_stk[i] = '0;
		end
	endtask

	task automatic expect_slot(input int i, input logic [PLAYER_PAD_W-1:0] b,
			input logic [STICK_W-1:0] s);
		exp_btn[i] = b;
		exp_stk[i] = s;
	endtask

	task automatic check_outputs(input string name);
		check_buttons({name, " p0"}, exp_btn[0], player0_buttons);
		check_buttons({name, " p1"}, exp_btn[1], player1_buttons);
		check_buttons({name, " p2"}, exp_btn[2], player2_buttons);
		check_buttons({name, " p3"}, exp_btn[3], player3_buttons);
		check_stick({name, " p0"}, exp_stk[0], player0_stick);
		check_stick({name, " p1"}, exp_stk[1], player1_stick);
		check_stick({name, " p2"}, exp_stk[2], player2_stick);
		check_stick({name, " p3"}, exp_stk[3], player3_stick);
		check_flag(name, exp_osd, osd_button);
	endtask

	task automatic wait_reset_release;
		int n;
		n = 0;
		while (RESET !== 1'b1 && n < 20) begin
			@(posedge clk_1x);
			n++;
		end
		if (RESET !== 1'b1) begin
			$display("Reset was still asserted after 20 cycles");
			$display("Simulation failed");
			$finish;
		end else begin
			@(negedge clk_1x);
		end
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	// Live pads sit on the inputs through reset, yet the first
	// registered values after release must still be empty
	task automatic test_reset;
		start_test();
		expect_empty();
		exp_osd = 1'b0;
		check_outputs("reset");
		finish_test("reset");
	endtask

	task automatic test_port_a_only;
		logic [LL_BUTTONS_W-1:0] b;
		logic [LL_ANALOG_W-1:0]  an;
		start_test();
		b  = $random(seed);
		an = {$random(seed), $random(seed), $random(seed)};
		drive_a(b, an, 8'd19, 1'b1);
		drive_b('0, '0, LL_TYPE_NONE, 1'b1);
		randomize_usb();
		settle_pipeline();
		expect_slot(0, map_pad(b), center(an));
		expect_slot(1, usb0_buttons, usb0_stick);
		expect_slot(2, usb1_buttons, usb1_stick);
		expect_slot(3, usb2_buttons, usb2_stick);
		exp_osd = combo(b);
		check_outputs("port_a_only");
		finish_test("port_a_only");
	endtask

	task automatic test_port_b_only;
		logic [LL_BUTTONS_W-1:0] b;
		logic [LL_ANALOG_W-1:0]  an;
		start_test();
		b  = $random(seed);
		an = {$random(seed), $random(seed), $random(seed)};
		drive_a('0, '0, 8'd5, 1'b0);
		drive_b(b, an, 8'd19, 1'b1);
		randomize_usb();
		settle_pipeline();
		expect_slot(0, map_pad(b), center(an));
		expect_slot(1, usb0_buttons, usb0_stick);
		expect_slot(2, usb1_buttons, usb1_stick);
		expect_slot(3, usb2_buttons, usb2_stick);
		exp_osd = combo(b);
		check_outputs("port_b_only");
		finish_test("port_b_only");
	endtask

	// USB pad 2 has no slot once both serial pads are in
	task automatic test_both_ports;
		logic [LL_BUTTONS_W-1:0] ba;
		logic [LL_BUTTONS_W-1:0] bb;
		logic [LL_ANALOG_W-1:0]  ana;
		logic [LL_ANALOG_W-1:0]  anb;
		start_test();
		ba  = $random(seed);
		bb  = $random(seed);
		ana = {$random(seed), $random(seed), $random(seed)};
		anb = {$random(seed), $random(seed), $random(seed)};
		drive_a(ba, ana, 8'd19, 1'b1);
		drive_b(bb, anb, 8'd3, 1'b1);
		randomize_usb();
		settle_pipeline();
		expect_slot(0, map_pad(ba), center(ana));
		expect_slot(1, map_pad(bb), center(anb));
		expect_slot(2, usb0_buttons, usb0_stick);
		expect_slot(3, usb1_buttons, usb1_stick);
		exp_osd = combo(ba) | combo(bb);
		check_outputs("both_ports");
		finish_test("both_ports");
	endtask

	task automatic test_presence;
		logic [LL_TYPE_W-1:0] types [3];
		logic                 ens [3];
		string                names [3];
		types = '{LL_TYPE_NONE, LL_TYPE_SEARCHING, 8'd19};
		ens   = '{1'b1, 1'b1, 1'b0};
		names = '{"presence type0", "presence type255", "presence en_low"};
		start_test();
		for (int c = 0; c < 3; c++) begin
			// Menu bits cleared so only presence matters
			drive_a($random(seed) & ~COMBO_BITS, {3{$random(seed)}}, types[c], ens[c]);
			drive_b($random(seed) & ~COMBO_BITS, {3{$random(seed)}}, types[c], ens[c]);
			randomize_usb();
			settle_pipeline();
			expect_empty();
			exp_osd = 1'b0;
			check_outputs(names[c]);
		end
		finish_test("presence");
	endtask

	task automatic test_menu_combo;
		start_test();
		drive_a(COMBO_BITS, '0, LL_TYPE_NONE, 1'b1);
		drive_b('0, '0, LL_TYPE_NONE, 1'b1);
		settle_pipeline();
		expect_empty();
		exp_osd = 1'b1;
		check_outputs("menu a held");
		drive_a(COMBO_BITS & ~32'h0000_0020, '0, LL_TYPE_NONE, 1'b1);
		settle_pipeline();
		exp_osd = 1'b0;
		check_outputs("menu a start released");
		drive_a('0, '0, LL_TYPE_NONE, 1'b1);
		drive_b(COMBO_BITS, '0, LL_TYPE_SEARCHING, 1'b1);
		settle_pipeline();
		exp_osd = 1'b1;
		check_outputs("menu b held");
		drive_b(COMBO_BITS & ~32'h0400_0000, '0, LL_TYPE_SEARCHING, 1'b1);
		settle_pipeline();
		exp_osd = 1'b0;
		check_outputs("menu b down released");
		drive_b(COMBO_BITS & ~32'h0000_0001, '0, LL_TYPE_SEARCHING, 1'b1);
		settle_pipeline();
		exp_osd = 1'b0;
		check_outputs("menu b first released");
		finish_test("menu_combo");
	endtask

	// Raw 0 lands on 128 and raw 255 on 127
	task automatic test_stick_wrap;
		start_test();
		drive_a('0, 72'h00FF, 8'd19, 1'b1);
		drive_b('0, '0, LL_TYPE_NONE, 1'b1);
		settle_pipeline();
		expect_slot(0, '0, {8'd128, 8'd127});
		expect_slot(1, usb0_buttons, usb0_stick);
		expect_slot(2, usb1_buttons, usb1_stick);
		expect_slot(3, usb2_buttons, usb2_stick);
		exp_osd = 1'b0;
		check_outputs("stick y0 x255");
		drive_a('0, 72'hFF00, 8'd19, 1'b1);
		settle_pipeline();
		expect_slot(0, '0, {8'd127, 8'd128});
		check_outputs("stick y255 x0");
		finish_test("stick_wrap");
	endtask

	initial begin
		seed = 32'hda05;
		// Both ports present with the menu held, USB pads busy
		drive_a(COMBO_BITS, {3{$random(seed)}}, 8'd19, 1'b1);
		drive_b(COMBO_BITS, {3{$random(seed)}}, 8'd19, 1'b1);
		randomize_usb();
		exp_osd = 1'b0;
		wait_reset_release();
		test_reset();
		test_port_a_only();
		test_port_b_only();
		test_both_ports();
		test_presence();
		test_menu_combo();
		test_stick_wrap();
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
			tests_run, tests_passed, tests_run - tests_passed, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== controller_input_top.sv ====
`timescale 1ns/100ps

module controller_input_top import pad_pkg::*; #(
	parameter int STICK_OFFSET = DEFAULT_STICK_OFFSET
) (
	input  logic                    clk_1x,
	input  logic                    RESET,

	// Serial port A, decoded by the link
	input  logic [LL_BUTTONS_W-1:0] ll_buttons_a,
	input  logic [LL_ANALOG_W-1:0]  ll_analog_a,
	input  logic [LL_TYPE_W-1:0]    ll_type_a,
	input  logic                    ll_en_a,

	// Serial port B, decoded by the link
	input  logic [LL_BUTTONS_W-1:0] ll_buttons_b,
	input  logic [LL_ANALOG_W-1:0]  ll_analog_b,
	input  logic [LL_TYPE_W-1:0]    ll_type_b,
	input  logic                    ll_en_b,

	// USB pads
	input  logic [PLAYER_PAD_W-1:0] usb0_buttons,
	input  logic [PLAYER_PAD_W-1:0] usb1_buttons,
	input  logic [PLAYER_PAD_W-1:0] usb2_buttons,
	input  logic [STICK_W-1:0]      usb0_stick,
	input  logic [STICK_W-1:0]      usb1_stick,
	input  logic [STICK_W-1:0]      usb2_stick,

	// Player slots
	output logic [PLAYER_PAD_W-1:0] player0_buttons,
	output logic [PLAYER_PAD_W-1:0] player1_buttons,
	output logic [PLAYER_PAD_W-1:0] player2_buttons,
	output logic [PLAYER_PAD_W-1:0] player3_buttons,
	output logic [STICK_W-1:0]      player0_stick,
	output logic [STICK_W-1:0]      player1_stick,
	output logic [STICK_W-1:0]      player2_stick,
	output logic [STICK_W-1:0]      player3_stick,
	output logic                    osd_button
);

	logic [LL_PAD_W-1:0] a_buttons;
	logic [STICK_W-1:0]  a_stick;
	logic                a_present;
	logic                a_combo;
	logic [LL_PAD_W-1:0] b_buttons;
	logic [STICK_W-1:0]  b_stick;
	logic                b_present;
	logic                b_combo;

	// One mapper per serial port
	llapi_pad_mapper #(
		.STICK_OFFSET (STICK_OFFSET)
	) map_a_i (
		.clk_1x      (clk_1x),
		.RESET       (RESET),
		.ll_buttons  (ll_buttons_a),
		.ll_analog   (ll_analog_a),
		.ll_type     (ll_type_a),
		.ll_en       (ll_en_a),
		.pad_buttons (a_buttons),
		.stick       (a_stick),
		.present     (a_present),
		.osd_combo   (a_combo)
	);

	llapi_pad_mapper #(
		.STICK_OFFSET (STICK_OFFSET)
	) map_b_i (
		.clk_1x      (clk_1x),
		.RESET       (RESET),
		.ll_buttons  (ll_buttons_b),
		.ll_analog   (ll_analog_b),
		.ll_type     (ll_type_b),
		.ll_en       (ll_en_b),
		.pad_buttons (b_buttons),
		.stick       (b_stick),
		.present     (b_present),
		.osd_combo   (b_combo)
	);

	// USB pads skip the mapper stage and arrive one cycle ahead
	player_allocator alloc_i (
		.clk_1x          (clk_1x),
		.RESET           (RESET),
		.a_buttons       (a_buttons),
		.a_stick         (a_stick),
		.a_present       (a_present),
		.a_combo         (a_combo),
		.b_buttons       (b_buttons),
		.b_stick         (b_stick),
		.b_present       (b_present),
		.b_combo         (b_combo),
		.usb0_buttons    (usb0_buttons),
		.usb1_buttons    (usb1_buttons),
		.usb2_buttons    (usb2_buttons),
		.usb0_stick      (usb0_stick),
		.usb1_stick      (usb1_stick),
		.usb2_stick      (usb2_stick),
		.player0_buttons (player0_buttons),
		.player1_buttons (player1_buttons),
		.player2_buttons (player2_buttons),
		.player3_buttons (player3_buttons),
		.player0_stick   (player0_stick),
		.player1_stick   (player1_stick),
		.player2_stick   (player2_stick),
		.player3_stick   (player3_stick),
		.osd_button      (osd_button)
	);

endmodule

// ==== player_allocator.sv ====
`timescale 1ns/100ps

module player_allocator import pad_pkg::*; (
	input  logic                    clk_1x,
	input  logic                    RESET,

	// Serial port A mapper
	input  logic [LL_PAD_W-1:0]     a_buttons,
	input  logic [STICK_W-1:0]      a_stick,
	input  logic                    a_present,
	input  logic                    a_combo,

	// Serial port B mapper
	input  logic [LL_PAD_W-1:0]     b_buttons,
	input  logic [STICK_W-1:0]      b_stick,
	input  logic                    b_present,
	input  logic                    b_combo,

	// USB pads from the host
	input  logic [PLAYER_PAD_W-1:0] usb0_buttons,
	input  logic [PLAYER_PAD_W-1:0] usb1_buttons,
	input  logic [PLAYER_PAD_W-1:0] usb2_buttons,
	input  logic [STICK_W-1:0]      usb0_stick,
	input  logic [STICK_W-1:0]      usb1_stick,
	input  logic [STICK_W-1:0]      usb2_stick,

	// Player slots
	output logic [PLAYER_PAD_W-1:0] player0_buttons,
	output logic [PLAYER_PAD_W-1:0] player1_buttons,
	output logic [PLAYER_PAD_W-1:0] player2_buttons,
	output logic [PLAYER_PAD_W-1:0] player3_buttons,
	output logic [STICK_W-1:0]      player0_stick,
	output logic [STICK_W-1:0]      player1_stick,
	output logic [STICK_W-1:0]      player2_stick,
	output logic [STICK_W-1:0]      player3_stick,
	output logic                    osd_button
);

	alloc_mode_t             mode;
	logic [PLAYER_PAD_W-1:0] a_wide;
	logic [PLAYER_PAD_W-1:0] b_wide;
	logic [PLAYER_PAD_W-1:0] slot_buttons [NUM_PLAYERS];
	logic [STICK_W-1:0]      slot_stick [NUM_PLAYERS];
	logic [PLAYER_PAD_W-1:0] out_buttons [NUM_PLAYERS];
	logic [STICK_W-1:0]      out_stick [NUM_PLAYERS];

	// Serial pads only fill the low bits of a player word
	assign a_wide = {{(PLAYER_PAD_W - LL_PAD_W){1'b0}}, a_buttons};
	assign b_wide = {{(PLAYER_PAD_W - LL_PAD_W){1'b0}}, b_buttons};

	always_comb begin
		case ({a_present, b_present})
			2'b10:   mode = ALLOC_A_ONLY;
			2'b01:   mode = ALLOC_B_ONLY;
			2'b11:   mode = ALLOC_BOTH;
			default: mode = ALLOC_NONE;
		endcase
	end

	// ========================================================================
	// Slot assignment
	// ========================================================================

	// Serial pads go first, USB pads fill what is left
	always_comb begin
		for (int i = 0; i < NUM_PLAYERS; i++) begin
			slot_buttons[i] = '0;
			slot_stick[i]   = '0;
		end
		case (mode)
			ALLOC_A_ONLY: begin
				slot_buttons[0] = a_wide;
				slot_stick[0]   = a_stick;
				slot_buttons[1] = usb0_buttons;
				slot_stick[1]   = usb0_stick;
				slot_buttons[2] = usb1_buttons;
				slot_stick[2]   = usb1_stick;
				slot_buttons[3] = usb2_buttons;
				slot_stick[3]   = usb2_stick;
			end
			ALLOC_B_ONLY: begin
				slot_buttons[0] = b_wide;
				slot_stick[0]   = b_stick;
				slot_buttons[1] = usb0_buttons;
				slot_stick[1]   = usb0_stick;
				slot_buttons[2] = usb1_buttons;
				slot_stick[2]   = usb1_stick;
				slot_buttons[3] = usb2_buttons;
				slot_stick[3]   = usb2_stick;
			end
			// USB pad 2 has no slot left here
			ALLOC_BOTH: begin
				slot_buttons[0] = a_wide;
				slot_stick[0]   = a_stick;
				slot_buttons[1] = b_wide;
				slot_stick[1]   = b_stick;
				slot_buttons[2] = usb0_buttons;
				slot_stick[2]   = usb0_stick;
				slot_buttons[3] = usb1_buttons;
				slot_stick[3]   = usb1_stick;
			end
			// No serial pad means every slot stays empty, USB included
			default: ;
		endcase
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			for (int i = 0; i < NUM_PLAYERS; i++) begin
				out_buttons[i] <= '0;
				out_stick[i]   <= '0;
			end
			osd_button <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_PLAYERS; i++) begin
				out_buttons[i] <= slot_buttons[i];
				out_stick[i]   <= slot_stick[i];
			end
			osd_button <= a_combo | b_combo;
		end
	end

	assign player0_buttons = out_buttons[0];
	assign player1_buttons = out_buttons[1];
	assign player2_buttons = out_buttons[2];
	assign player3_buttons = out_buttons[3];
	assign player0_stick   = out_stick[0];
	assign player1_stick   = out_stick[1];
	assign player2_stick   = out_stick[2];
	assign player3_stick   = out_stick[3];

endmodule

// ==== llapi_pad_mapper.sv ====
`timescale 1ns/100ps

module llapi_pad_mapper import pad_pkg::*; #(
	parameter int STICK_OFFSET = DEFAULT_STICK_OFFSET
) (
	input  logic                    clk_1x,
	input  logic                    RESET,
	input  logic [LL_BUTTONS_W-1:0] ll_buttons,
	input  logic [LL_ANALOG_W-1:0]  ll_analog,
	input  logic [LL_TYPE_W-1:0]    ll_type,
	input  logic                    ll_en,
	output logic [LL_PAD_W-1:0]     pad_buttons,
	output logic [STICK_W-1:0]      stick,
	output logic                    present,
	output logic                    osd_combo
);

	// ========================================================================
	// Button remap
	// ========================================================================

	// Source button index for each player bit, bit 13 first
	// C left, C down, C right, C up, Z, R, L, start, B, A, then the d-pad
	localparam int BTN_SRC [LL_PAD_W-1:0] = '{
		2, 3, 9, 8,
		4, 7, 6, 5,
		0, 1,
		27, 26, 25, 24
	};

	// Buttons that make up the menu combination
	localparam int BTN_DOWN  = 26;
	localparam int BTN_START = 5;
	localparam int BTN_FIRST = 0;

	// Offset cut down to one axis
	localparam logic [AXIS_W-1:0] OFFSET_AXIS = AXIS_W'(STICK_OFFSET);

	logic [LL_PAD_W-1:0] pad_map;
	logic [AXIS_W-1:0]   stick_x;
	logic [AXIS_W-1:0]   stick_y;
	logic                pad_seen;
	logic                combo_held;

	always_comb begin
		for (int i = 0; i < LL_PAD_W; i++) begin
			pad_map[i] = ll_buttons[BTN_SRC[i]];
		end
	end

	// ========================================================================
	// Stick re-centring
	// ========================================================================

	// Both axes wrap modulo 256
	assign stick_x = ll_analog[AXIS_W-1:0] - OFFSET_AXIS;
	assign stick_y = ll_analog[STICK_W-1:AXIS_W] - OFFSET_AXIS;

	// ========================================================================
	// Presence and menu combination
	// ========================================================================

	// Type 0 and type 255 both count as no pad
	assign pad_seen = ll_en
		&& (ll_type != LL_TYPE_NONE)
		&& (ll_type != LL_TYPE_SEARCHING);

	// Down + start + first button, taken straight from the raw word
	// so it works even when the pad is not counted as present
	assign combo_held = ll_buttons[BTN_DOWN]
		& ll_buttons[BTN_START]
		& ll_buttons[BTN_FIRST];

	// Payload registers
	always_ff @(posedge clk_1x) begin
		pad_buttons <= pad_map;
		stick       <= {stick_y, stick_x};
	end

	// Status flags
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			present   <= 1'b0;
			osd_combo <= 1'b0;
		end else begin
			present   <= pad_seen;
			osd_combo <= combo_held;
		end
	end

endmodule

// ==== pad_pkg.sv ====
package pad_pkg;

	// ========================================================================
	// Serial port words
	// ========================================================================

	// Decoded button word from one serial port
	localparam int LL_BUTTONS_W = 32;

	// Analog word from one serial port
	// Only the left stick in the low 16 bits is used
	localparam int LL_ANALOG_W = 72;

	// Device type code reported by the link
	localparam int LL_TYPE_W = 8;

	// Button word after remapping into player order
	localparam int LL_PAD_W = 14;

	// ========================================================================
	// Player words
	// ========================================================================

	// Player and USB button word
	// Serial pads are zero-extended up to this width
	localparam int PLAYER_PAD_W = 20;

	// One stick axis
	localparam int AXIS_W = 8;

	// Packed stick word, Y in the high byte and X in the low byte
	localparam int STICK_W = 2 * AXIS_W;

	// Player slots fed to the console
	localparam int NUM_PLAYERS = 4;

	// ========================================================================
	// Device types and defaults
	// ========================================================================

	// No pad attached, or a pad the core does not understand
	localparam logic [LL_TYPE_W-1:0] LL_TYPE_NONE = 8'd0;

	// Link still looking for a pad
	localparam logic [LL_TYPE_W-1:0] LL_TYPE_SEARCHING = 8'd255;

	// Raw stick bytes are unsigned with centre at 128
	localparam int DEFAULT_STICK_OFFSET = 128;

	// Which serial ports take player slots
	typedef enum logic [1:0] {
		ALLOC_NONE   = 2'd0,
		ALLOC_A_ONLY = 2'd1,
		ALLOC_B_ONLY = 2'd2,
		ALLOC_BOTH   = 2'd3
	} alloc_mode_t;

endpackage
